//--- rtl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  ir_type_t;

    // Major opcodes that need a non-ALU writeback source
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // Load widths
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // CSR ops, immediate forms differ only in bit 2
    localparam funct3_t F3_CSRRW = 3'b001;
    localparam funct3_t F3_CSRRS = 3'b010;
    localparam funct3_t F3_CSRRC = 3'b011;

    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;

endpackage

`default_nettype wire

//--- rtl/mem_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_wb_if;

    wb_pkg::word_t     pc4;       // Link address
    wb_pkg::word_t     c;         // ALU result
    wb_pkg::word_t     d;         // Aligned load data
    wb_pkg::word_t     z;         // Old CSR value
    wb_pkg::funct3_t   funct3;
    wb_pkg::reg_addr_t rd;
    wb_pkg::csr_addr_t csr_addr;
    wb_pkg::opcode_t   opcode;
    wb_pkg::ir_type_t  ir_type;
    logic              wr_reg_n;  // Active low
    logic              wr_csr_n;  // Active low

    modport src (
        output pc4,
        output c,
        output d,
        output z,
        output funct3,
        output rd,
        output csr_addr,
        output opcode,
        output ir_type,
        output wr_reg_n,
        output wr_csr_n
    );

    modport dst (
        input pc4,
        input c,
        input d,
        input z,
        input funct3,
        input rd,
        input csr_addr,
        input opcode,
        input ir_type,
        input wr_reg_n,
        input wr_csr_n
    );

endinterface

`default_nettype wire

//--- rtl/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  wb_pkg::word_t   mem_rdata,
    input  logic [1:0]      addr_lo,
    input  wb_pkg::funct3_t funct3,
    output wb_pkg::word_t   load_data
);

    wb_pkg::word_t shifted;
    logic [7:0]    byte_val;
    logic [15:0]   half_val;

    // Bring the addressed byte down to bit 0
    assign shifted  = mem_rdata >> {addr_lo, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    always_comb begin
        case (funct3)
            wb_pkg::F3_LB: begin
                load_data = {{24{byte_val[7]}}, byte_val};
            end
            wb_pkg::F3_LH: begin
                load_data = {{16{half_val[15]}}, half_val};
            end
            wb_pkg::F3_LBU: begin
                load_data = {24'd0, byte_val};
            end
            wb_pkg::F3_LHU: begin
                load_data = {16'd0, half_val};
            end
            wb_pkg::F3_LW: begin
                load_data = shifted;
            end
            default: begin
                load_data = shifted;  // Undefined widths pass the word
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              interlock,
    input  wb_pkg::csr_addr_t csr_addr,
    input  wb_pkg::funct3_t   funct3,
    input  wb_pkg::word_t     operand,
    input  logic              wr_csr_n,
    output wb_pkg::word_t     old_value
);

    wb_pkg::word_t mscratch;
    wb_pkg::word_t mepc;
    wb_pkg::word_t mcause;
    wb_pkg::word_t mtval;
    wb_pkg::word_t new_value;
    logic          write_en;

    always_comb begin
        case (csr_addr)
            wb_pkg::CSR_MSCRATCH: old_value = mscratch;
            wb_pkg::CSR_MEPC:     old_value = mepc;
            wb_pkg::CSR_MCAUSE:   old_value = mcause;
            wb_pkg::CSR_MTVAL:    old_value = mtval;
            default:              old_value = '0;  // Unimplemented CSR
        endcase
    end

    // Bit 2 only selects the immediate form, operand is already resolved
    always_comb begin
        case (funct3[1:0])
            wb_pkg::F3_CSRRW[1:0]: new_value = operand;
            wb_pkg::F3_CSRRS[1:0]: new_value = old_value | operand;
            wb_pkg::F3_CSRRC[1:0]: new_value = old_value & ~operand;
            default:               new_value = old_value;
        endcase
    end

    assign write_en = !wr_csr_n && !interlock;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (write_en) begin
            case (csr_addr)
                wb_pkg::CSR_MSCRATCH: mscratch <= new_value;
                wb_pkg::CSR_MEPC:     mepc     <= new_value;
                wb_pkg::CSR_MCAUSE:   mcause   <= new_value;
                wb_pkg::CSR_MTVAL:    mtval    <= new_value;
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_regs (
    input logic     clk,
    input logic     rst_n,
    input logic     interlock,
    mem_wb_if.dst   ex_bus,
    mem_wb_if.src   wb_bus
);

    // Write flags are the only control state here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_bus.wr_reg_n <= 1'b1;  // Not writing
            wb_bus.wr_csr_n <= 1'b1;
        end else if (!interlock) begin
            wb_bus.wr_reg_n <= ex_bus.wr_reg_n;
            wb_bus.wr_csr_n <= ex_bus.wr_csr_n;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            wb_bus.pc4      <= ex_bus.pc4;
            wb_bus.c        <= ex_bus.c;
            wb_bus.d        <= ex_bus.d;
            wb_bus.z        <= ex_bus.z;
            wb_bus.funct3   <= ex_bus.funct3;
            wb_bus.rd       <= ex_bus.rd;
            wb_bus.csr_addr <= ex_bus.csr_addr;
            wb_bus.opcode   <= ex_bus.opcode;
            wb_bus.ir_type  <= ex_bus.ir_type;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wb_select.sv
`timescale 1ns/1ps
`default_nettype none

module wb_select (
    mem_wb_if.dst             wb_bus,
    output logic              rf_we,
    output wb_pkg::reg_addr_t rf_waddr,
    output wb_pkg::word_t     rf_wdata
);

    always_comb begin
        case (wb_bus.opcode)
            wb_pkg::OPC_LOAD:   rf_wdata = wb_bus.d;
            wb_pkg::OPC_JAL:    rf_wdata = wb_bus.pc4;
            wb_pkg::OPC_JALR:   rf_wdata = wb_bus.pc4;
            wb_pkg::OPC_SYSTEM: rf_wdata = wb_bus.z;  // CSR old value
            default:            rf_wdata = wb_bus.c;
        endcase
    end

    // x0 is never written
    assign rf_we    = !wb_bus.wr_reg_n && (wb_bus.rd != '0);
    assign rf_waddr = wb_bus.rd;

endmodule

`default_nettype wire

//--- rtl/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              interlock,
    input  wb_pkg::word_t     pc4,
    input  wb_pkg::word_t     alu_result,
    input  wb_pkg::word_t     mem_rdata,
    input  wb_pkg::funct3_t   funct3,
    input  wb_pkg::reg_addr_t rd,
    input  wb_pkg::csr_addr_t csr_addr,
    input  wb_pkg::opcode_t   opcode,
    input  wb_pkg::ir_type_t  ir_type,
    input  logic              wr_reg_n,
    input  logic              wr_csr_n,
    output logic              rf_we,
    output wb_pkg::reg_addr_t rf_waddr,
    output wb_pkg::word_t     rf_wdata,
    output wb_pkg::ir_type_t  ir_type_out,
    output wb_pkg::csr_addr_t csr_addr_out
);

    mem_wb_if ex_bus ();
    mem_wb_if wb_bus ();

    assign ex_bus.pc4      = pc4;
    assign ex_bus.c        = alu_result;
    assign ex_bus.funct3   = funct3;
    assign ex_bus.rd       = rd;
    assign ex_bus.csr_addr = csr_addr;
    assign ex_bus.opcode   = opcode;
    assign ex_bus.ir_type  = ir_type;
    assign ex_bus.wr_reg_n = wr_reg_n;
    assign ex_bus.wr_csr_n = wr_csr_n;

    load_align u_load_align (
        .mem_rdata (mem_rdata),
        .addr_lo   (alu_result[1:0]),  // Byte offset of the load
        .funct3    (ex_bus.funct3),
        .load_data (ex_bus.d)
    );

    csr_unit u_csr_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .interlock (interlock),
        .csr_addr  (ex_bus.csr_addr),
        .funct3    (ex_bus.funct3),
        .operand   (alu_result),
        .wr_csr_n  (ex_bus.wr_csr_n),
        .old_value (ex_bus.z)
    );

    mem_wb_regs u_mem_wb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .interlock (interlock),
        .ex_bus    (ex_bus.dst),
        .wb_bus    (wb_bus.src)
    );

    wb_select u_wb_select (
        .wb_bus   (wb_bus.dst),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    // Feed the hazard logic
    assign ir_type_out  = wb_bus.ir_type;
    assign csr_addr_out = wb_bus.csr_addr;

endmodule

`default_nettype wire

//--- sim/mem_wb_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_properties (
    input logic         clk,
    input logic         rst_n,
    input logic         interlock,
    input logic         wr_reg_n,
    input logic [160:0] wb_fields
);

    int fail_count = 0;  // Summed into the testbench error count

    a_reset_no_write: assert property (
        @(posedge clk) !rst_n |-> wr_reg_n
    ) else begin
        fail_count++;
        $error("wr_reg_n is low while rst_n is low");
    end

    // A stalled edge leaves the whole bundle as it was
    a_interlock_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(interlock) && $past(rst_n) |-> wb_fields == $past(wb_fields)
    ) else begin
        fail_count++;
        $error("wb_bus changed across an edge with interlock high");
    end

endmodule

`default_nettype wire

//--- sim/tb_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb;

    localparam int MAX_ROWS  = 128;
    localparam int RAND_ROWS = 20;

    typedef struct {
        logic              stall;
        wb_pkg::opcode_t   opcode;
        wb_pkg::funct3_t   funct3;
        wb_pkg::reg_addr_t rd;
        wb_pkg::word_t     alu;
        wb_pkg::word_t     rdata;
        wb_pkg::word_t     pc4;
        wb_pkg::csr_addr_t csr;
        wb_pkg::ir_type_t  ir_type;
        logic              wr_reg_n;
        logic              wr_csr_n;
        logic              exp_we;
        wb_pkg::reg_addr_t exp_waddr;
        wb_pkg::word_t     exp_wdata;
        int                src;       // Row whose results sit in the pipeline register
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              interlock;
    wb_pkg::word_t     pc4;
    wb_pkg::word_t     alu_result;
    wb_pkg::word_t     mem_rdata;
    wb_pkg::funct3_t   funct3;
    wb_pkg::reg_addr_t rd;
    wb_pkg::csr_addr_t csr_addr;
    wb_pkg::opcode_t   opcode;
    wb_pkg::ir_type_t  ir_type;
    logic              wr_reg_n;
    logic              wr_csr_n;
    logic              rf_we;
    wb_pkg::reg_addr_t rf_waddr;
    wb_pkg::word_t     rf_wdata;
    wb_pkg::ir_type_t  ir_type_out;
    wb_pkg::csr_addr_t csr_addr_out;

    row_t          rows [MAX_ROWS];
    wb_pkg::word_t model_csr [4];
    int            num_rows;
    int            errors;
    int            cur_row;
    integer        seed;
    logic          table_ready;

    mem_wb_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .interlock    (interlock),
        .pc4          (pc4),
        .alu_result   (alu_result),
        .mem_rdata    (mem_rdata),
        .funct3       (funct3),
        .rd           (rd),
        .csr_addr     (csr_addr),
        .opcode       (opcode),
        .ir_type      (ir_type),
        .wr_reg_n     (wr_reg_n),
        .wr_csr_n     (wr_csr_n),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .ir_type_out  (ir_type_out),
        .csr_addr_out (csr_addr_out)
    );

    bind mem_wb_regs mem_wb_properties u_properties (
        .clk       (clk),
        .rst_n     (rst_n),
        .interlock (interlock),
        .wr_reg_n  (wb_bus.wr_reg_n),
        .wb_fields ({wb_bus.pc4, wb_bus.c, wb_bus.d, wb_bus.z, wb_bus.funct3, wb_bus.rd,
                     wb_bus.csr_addr, wb_bus.opcode, wb_bus.ir_type, wb_bus.wr_reg_n,
                     wb_bus.wr_csr_n})
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Error: %s is 0x%08h, expected 0x%08h (row %0d)",
                     name, actual, expected, cur_row);
        end
    endtask

    task automatic add_row(input logic stall, input wb_pkg::opcode_t opc,
                           input wb_pkg::funct3_t f3, input wb_pkg::reg_addr_t dest,
                           input wb_pkg::word_t alu, input wb_pkg::word_t rdata,
                           input wb_pkg::word_t link, input wb_pkg::csr_addr_t csr,
                           input logic no_reg_wr, input logic no_csr_wr);
        rows[num_rows].stall    = stall;
        rows[num_rows].opcode   = opc;
        rows[num_rows].funct3   = f3;
        rows[num_rows].rd       = dest;
        rows[num_rows].alu      = alu;
        rows[num_rows].rdata    = rdata;
        rows[num_rows].pc4      = link;
        rows[num_rows].csr      = csr;
        rows[num_rows].ir_type  = 4'(num_rows);
        rows[num_rows].wr_reg_n = no_reg_wr;
        rows[num_rows].wr_csr_n = no_csr_wr;
        num_rows++;
    endtask

    task automatic add_csr(input logic stall, input wb_pkg::funct3_t f3,
                           input wb_pkg::csr_addr_t csr, input wb_pkg::word_t operand,
                           input wb_pkg::reg_addr_t dest);
        add_row(stall, wb_pkg::OPC_SYSTEM, f3, dest, operand, 32'h0, 32'h0, csr, 1'b0, 1'b0);
    endtask

    task automatic build_directed();
        wb_pkg::funct3_t load_f3 [5];
        load_f3 = '{wb_pkg::F3_LB, wb_pkg::F3_LH, wb_pkg::F3_LW, wb_pkg::F3_LBU, wb_pkg::F3_LHU};
        for (int f = 0; f < 5; f++) begin
            for (int off = 0; off < 4; off++) begin
                add_row(1'b0, wb_pkg::OPC_LOAD, load_f3[f], 5'(f * 4 + off + 1),
                        32'h0000_1000 + 32'(off), f[0] ? 32'hB31C_857A : 32'h4CE3_7A85,
                        32'h0, 12'h0, 1'b0, 1'b1);
            end
        end
        add_row(1'b0, 7'b0110011, 3'b000, 5'd7, 32'h1234_5678, 32'h0, 32'h0, 12'h0, 1'b0, 1'b1);
        add_row(1'b0, 7'b0010011, 3'b000, 5'd0, 32'hFFFF_0001, 32'h0, 32'h0, 12'h0, 1'b0, 1'b1);
        add_row(1'b0, wb_pkg::OPC_JAL, 3'b000, 5'd1, 32'h0000_2040, 32'h0, 32'h0000_1004,
                12'h0, 1'b0, 1'b1);
        add_row(1'b0, wb_pkg::OPC_JALR, 3'b000, 5'd0, 32'h0000_3000, 32'h0, 32'h0000_1008,
                12'h0, 1'b0, 1'b1);
        add_row(1'b0, 7'b0100011, 3'b010, 5'd9, 32'h0000_0ABC, 32'h0, 32'h0, 12'h0, 1'b1, 1'b1);
        add_csr(1'b0, wb_pkg::F3_CSRRW, wb_pkg::CSR_MSCRATCH, 32'hDEAD_BEEF, 5'd10);
        add_csr(1'b0, wb_pkg::F3_CSRRS, wb_pkg::CSR_MSCRATCH, 32'h0000_00F0, 5'd11);
        add_csr(1'b0, wb_pkg::F3_CSRRC, wb_pkg::CSR_MSCRATCH, 32'h0F0F_0000, 5'd12);
        add_csr(1'b0, wb_pkg::F3_CSRRS, wb_pkg::CSR_MSCRATCH, 32'h0, 5'd13);
        add_csr(1'b0, wb_pkg::F3_CSRRW | 3'b100, wb_pkg::CSR_MEPC, 32'h8000_0010, 5'd14);
        add_csr(1'b0, wb_pkg::F3_CSRRS, wb_pkg::CSR_MEPC, 32'h0, 5'd15);
        add_csr(1'b0, wb_pkg::F3_CSRRS | 3'b100, wb_pkg::CSR_MCAUSE, 32'h0000_000B, 5'd16);
        add_csr(1'b0, wb_pkg::F3_CSRRC | 3'b100, wb_pkg::CSR_MCAUSE, 32'h0000_0003, 5'd17);
        add_csr(1'b0, wb_pkg::F3_CSRRS, wb_pkg::CSR_MCAUSE, 32'h0, 5'd18);
        add_csr(1'b0, wb_pkg::F3_CSRRW, 12'h7C0, 32'h5555_AAAA, 5'd19);  // Unknown CSR
        add_csr(1'b0, wb_pkg::F3_CSRRS, 12'h7C0, 32'h0, 5'd20);
        add_csr(1'b0, wb_pkg::F3_CSRRW, wb_pkg::CSR_MTVAL, 32'h0000_1111, 5'd21);
        add_csr(1'b1, wb_pkg::F3_CSRRW, wb_pkg::CSR_MTVAL, 32'h0000_2222, 5'd22);  // Stalled
        add_csr(1'b1, wb_pkg::F3_CSRRS, wb_pkg::CSR_MSCRATCH, 32'hFFFF_FFFF, 5'd23);
        add_csr(1'b0, wb_pkg::F3_CSRRS, wb_pkg::CSR_MTVAL, 32'h0, 5'd24);
        add_csr(1'b0, wb_pkg::F3_CSRRS, wb_pkg::CSR_MSCRATCH, 32'h0, 5'd25);
    endtask

    task automatic build_random();
        wb_pkg::opcode_t   opc_pick [6];
        wb_pkg::funct3_t   load_f3 [5];
        wb_pkg::opcode_t   opc;
        wb_pkg::funct3_t   f3;
        logic              stall;
        logic              no_reg_wr;
        wb_pkg::csr_addr_t csr;
        opc_pick = '{wb_pkg::OPC_LOAD, wb_pkg::OPC_JAL, wb_pkg::OPC_JALR, wb_pkg::OPC_SYSTEM,
                     7'b0110011, 7'b0010011};
        load_f3 = '{wb_pkg::F3_LB, wb_pkg::F3_LH, wb_pkg::F3_LW, wb_pkg::F3_LBU, wb_pkg::F3_LHU};
        for (int n = 0; n < RAND_ROWS; n++) begin
            opc = opc_pick[$unsigned($random(seed)) % 6];
            if (opc == wb_pkg::OPC_LOAD) begin
                f3 = load_f3[$unsigned($random(seed)) % 5];
            end else if (opc == wb_pkg::OPC_SYSTEM) begin
                f3 = 3'(1 + $unsigned($random(seed)) % 3);  // RW, RS or RC
                if (($random(seed) & 1) != 0) begin
                    f3 = f3 | 3'b100;
                end
            end else begin
                f3 = 3'($random(seed));
            end
            stall     = ($random(seed) & 7) == 0;
            no_reg_wr = ($random(seed) & 3) == 0;
            csr       = 12'h340 + 12'($unsigned($random(seed)) % 6);  // Two unknown addresses
            add_row(stall, opc, f3, 5'($random(seed)), $random(seed), $random(seed),
                    $random(seed), csr, no_reg_wr, opc != wb_pkg::OPC_SYSTEM);
        end
    endtask

    function automatic wb_pkg::word_t aligned_load(input wb_pkg::word_t raw,
                                                   input logic [1:0] off,
                                                   input wb_pkg::funct3_t f3);
        wb_pkg::word_t w;
        w = raw >> (8 * off);
        case (f3)
            wb_pkg::F3_LB:  return 32'($signed(w[7:0]));
            wb_pkg::F3_LH:  return 32'($signed(w[15:0]));
            wb_pkg::F3_LBU: return {24'd0, w[7:0]};
            wb_pkg::F3_LHU: return {16'd0, w[15:0]};
            default:        return w;
        endcase
    endfunction

    task automatic fill_expected();
        wb_pkg::word_t old;
        logic          known;
        int            idx;
        for (int k = 0; k < 4; k++) begin
            model_csr[k] = '0;
        end
        for (int i = 0; i < num_rows; i++) begin
            if (rows[i].stall && i > 0) begin
                rows[i].exp_we    = rows[i - 1].exp_we;  // Outputs frozen, CSRs untouched
                rows[i].exp_waddr = rows[i - 1].exp_waddr;
                rows[i].exp_wdata = rows[i - 1].exp_wdata;
                rows[i].src       = rows[i - 1].src;
            end else begin
                known = rows[i].csr >= wb_pkg::CSR_MSCRATCH && rows[i].csr <= wb_pkg::CSR_MTVAL;
                idx   = int'(rows[i].csr - wb_pkg::CSR_MSCRATCH);
                old   = '0;
                if (known) begin
                    old = model_csr[idx];
                end
                case (rows[i].opcode)
                    wb_pkg::OPC_LOAD: begin
                        rows[i].exp_wdata = aligned_load(rows[i].rdata, rows[i].alu[1:0],
                                                         rows[i].funct3);
                    end
                    wb_pkg::OPC_JAL:    rows[i].exp_wdata = rows[i].pc4;
                    wb_pkg::OPC_JALR:   rows[i].exp_wdata = rows[i].pc4;
                    wb_pkg::OPC_SYSTEM: rows[i].exp_wdata = old;
                    default:            rows[i].exp_wdata = rows[i].alu;
                endcase
                rows[i].exp_we    = !rows[i].wr_reg_n && rows[i].rd != 5'd0;
                rows[i].exp_waddr = rows[i].rd;
                rows[i].src       = i;
                if (!rows[i].wr_csr_n && known) begin
                    case (rows[i].funct3 & 3'b011)
                        wb_pkg::F3_CSRRW: model_csr[idx] = rows[i].alu;
                        wb_pkg::F3_CSRRS: model_csr[idx] = old | rows[i].alu;
                        wb_pkg::F3_CSRRC: model_csr[idx] = old & ~rows[i].alu;
                        default: begin
                        end
                    endcase
                end
            end
        end
    endtask

    task automatic idle_inputs();
        interlock  = 1'b0;
        pc4        = '0;
        alu_result = '0;
        mem_rdata  = '0;
        funct3     = '0;
        rd         = '0;
        csr_addr   = '0;
        opcode     = 7'b0010011;
        ir_type    = '0;
        wr_reg_n   = 1'b1;
        wr_csr_n   = 1'b1;
    endtask

    task automatic drive_row(input int i);
        interlock  = rows[i].stall;
        pc4        = rows[i].pc4;
        alu_result = rows[i].alu;
        mem_rdata  = rows[i].rdata;
        funct3     = rows[i].funct3;
        rd         = rows[i].rd;
        csr_addr   = rows[i].csr;
        opcode     = rows[i].opcode;
        ir_type    = rows[i].ir_type;
        wr_reg_n   = rows[i].wr_reg_n;
        wr_csr_n   = rows[i].wr_csr_n;
    endtask

    initial begin
        errors      = 0;
        num_rows    = 0;
        cur_row     = -1;
        seed        = 5547;
        table_ready = 1'b0;
        rst_n       = 1'b1;
        idle_inputs();
        build_directed();
        build_random();
        fill_expected();
        table_ready = 1'b1;
        @(negedge clk);
        rst_n    = 1'b0;
        wr_reg_n = 1'b0;  // Pending write that reset has to block
        rd       = 5'd31;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_value("rf_we", 32'(rf_we), 32'd0);
        idle_inputs();
        for (int i = 0; i < num_rows; i++) begin
            drive_row(i);
            @(negedge clk);
            cur_row = i;
            check_value("rf_we", 32'(rf_we), 32'(rows[i].exp_we));
            check_value("rf_waddr", 32'(rf_waddr), 32'(rows[i].exp_waddr));
            check_value("rf_wdata", rf_wdata, rows[i].exp_wdata);
            check_value("ir_type_out", 32'(ir_type_out), 32'(rows[rows[i].src].ir_type));
            check_value("csr_addr_out", 32'(csr_addr_out), 32'(rows[rows[i].src].csr));
        end
        errors += DUT.u_mem_wb_regs.u_properties.fail_count;
        $display("tb_mem_wb: %0d rows applied, %0d errors", num_rows, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Each row takes one 20 ns cycle, so twice that leaves ample room
    initial begin
        wait (table_ready);
        #(num_rows * 40 + 500);
        $display("Timeout: the table was not finished in time, %0d errors so far", errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/wb_pkg.sv
rtl/mem_wb_if.sv
rtl/load_align.sv
rtl/csr_unit.sv
rtl/mem_wb_regs.sv
rtl/wb_select.sv
rtl/mem_wb_top.sv
sim/mem_wb_properties.sv
sim/tb_mem_wb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the MEM/WB testbench with Verilator, run it and judge the log.
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_wb -f files.f -o tb_mem_wb > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/tb_mem_wb +verilator+error+limit+100 > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$sim_log"; then
    exit 1
fi
exit 0
